// File: tb.f
+incdir+rtl
rtl/sensor_pkg.sv
rtl/drive_pkg.sv
rtl/sensor_sampler.sv
rtl/frame_fifo.sv
rtl/line_follower.sv
rtl/pwm_generator.sv
rtl/line_follower_top.sv
sim/line_follower_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module line_follower_tb -o line_follower_sim

out=$(./obj_dir/line_follower_sim)
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    exit 1
fi

// File: sim/line_follower_tb.sv
`timescale 1ns/1ps
`include "robot_settings.svh"

module line_follower_tb;

    // expected follower state that moves on once for every frame taken from the FIFO.
    typedef struct packed {
        logic                   at_node;
        logic signed [3:0]      prev_err;
        logic [3:0]             node_count;
        drive_pkg::drive_cmd_t  cmd;
        drive_pkg::led_status_t leds;
    } model_t;

    localparam drive_pkg::led_status_t leds_red = '{red: 3'b111, green: 3'b000, blue: 3'b000};
    localparam drive_pkg::led_status_t leds_green = '{red: 3'b000, green: 3'b111, blue: 3'b000};
    localparam drive_pkg::led_status_t leds_blue = '{red: 3'b000, green: 3'b000, blue: 3'b111};

    logic                    clk;
    logic                    rst;
    logic                    sample_valid;
    sensor_pkg::adc_sample_t left;
    sensor_pkg::adc_sample_t middle;
    sensor_pkg::adc_sample_t right;
    logic                    m1_a;
    logic                    m1_b;
    logic                    m2_a;
    logic                    m2_b;
    drive_pkg::duty_t        dc_left;
    drive_pkg::duty_t        dc_right;
    logic                    pwm_left;
    logic                    pwm_right;
    drive_pkg::led_status_t  leds;
    logic [3:0]              node_count;
    logic                    sample_dropped;

    model_t      model;
    logic [2:0]  line_model;
    logic [2:0]  pending_q[$];
    logic [2:0]  fifo_q[$];
    logic        push_pend;
    logic        exp_dropped;
    logic        armed;
    int          hi_l;
    int          hi_r;
    int          period_l;
    int          period_r;
    int          errors;
    int          checks;
    int          drops_seen;

    line_follower_top line_follower_top_i (
        .clk            (clk),
        .rst            (rst),
        .sample_valid   (sample_valid),
        .left           (left),
        .middle         (middle),
        .right          (right),
        .m1_a           (m1_a),
        .m1_b           (m1_b),
        .m2_a           (m2_a),
        .m2_b           (m2_b),
        .dc_left        (dc_left),
        .dc_right       (dc_right),
        .pwm_left       (pwm_left),
        .pwm_right      (pwm_right),
        .leds           (leds),
        .node_count     (node_count),
        .sample_dropped (sample_dropped)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic line_bit_after(input logic [11:0] value, input logic old_bit);
        if (value > `LINE_HIGH_THRESH) begin
            return 1'b1;
        end
        if (value < `LINE_LOW_THRESH) begin
            return 1'b0;
        end
        return old_bit;
    endfunction

    function automatic logic [3:0] clamp_duty(input int value);
        if (value < 0) begin
            return 4'd0;
        end
        if (value > `DUTY_MAX) begin
            return 4'(`DUTY_MAX);
        end
        return value[3:0];
    endfunction

    // the left wheel always runs forward, the right one reverses at a node.
    function automatic drive_pkg::drive_cmd_t make_cmd(input logic right_fwd, input int dl,
                                                       input int dr);
        drive_pkg::drive_cmd_t c;
        c.left_dir.a  = 1'b1;
        c.left_dir.b  = 1'b0;
        c.right_dir.a = right_fwd;
        c.right_dir.b = !right_fwd;
        c.left_duty   = clamp_duty(dl);
        c.right_duty  = clamp_duty(dr);
        return c;
    endfunction

    function automatic model_t follow_ref(input logic [2:0] bits, input model_t s);
        model_t n;
        int     err;
        int     prev;
        int     corr;
        int     base_l;
        int     base_r;
        n    = s;
        prev = $signed(s.prev_err);
        if (bits == 3'b111) begin
            if (!s.at_node) begin
                n.node_count = s.node_count + 4'd1;
            end
            n.at_node = 1'b1;
            n.cmd     = make_cmd(1'b0, 7, 3);
            n.leds    = leds_blue;
        end else if (bits == 3'b000) begin
            n.at_node = 1'b0;
            n.leds    = leds_red;
        end else begin
            case (bits)
                3'b110:  err = -1;
                3'b100:  err = -2;
                3'b011:  err = 1;
                3'b001:  err = 2;
                default: err = 0;
            endcase
            base_l = (err < 0) ? 4 : 7;
            base_r = (err > 0) ? 4 : 7;
            corr       = `KP * err + `KD * (err - prev);
            n.at_node  = 1'b0;
            n.prev_err = err[3:0];
            n.cmd      = make_cmd(1'b1, base_l + corr, base_r - corr);
            n.leds     = leds_green;
        end
        return n;
    endfunction

    // mirrors the sampler push, the FIFO fill and each pop of the DUT.
    always @(posedge clk) begin
        logic [2:0] bits;
        logic       full_pre;
        if (rst) begin
            model       = '{at_node: 1'b0, prev_err: 4'sd0, node_count: 4'd0,
                            cmd: make_cmd(1'b1, 0, 0), leds: leds_green};
            fifo_q.delete();
            pending_q.delete();
            push_pend   = 1'b0;
            exp_dropped = 1'b0;
            armed       = 1'b0;
            hi_l        = 0;
            hi_r        = 0;
            period_l    = 0;
            period_r    = 0;
        end else begin
            armed = 1'b1;
            hi_l += int'(pwm_left);
            hi_r += int'(pwm_right);
            if (line_follower_top_i.update) begin
                check_value("pwm_left high count", hi_l, period_l);
                check_value("pwm_right high count", hi_r, period_r);
                period_l = model.cmd.left_duty;
                period_r = model.cmd.right_duty;
                hi_l     = 0;
                hi_r     = 0;
            end
            full_pre = (fifo_q.size() == `FIFO_DEPTH);
            if (line_follower_top_i.update && fifo_q.size() != 0) begin
                bits  = fifo_q.pop_front();
                model = follow_ref(bits, model);
            end
            exp_dropped = 1'b0;
            if (push_pend) begin
                bits = pending_q.pop_front();
                if (full_pre) begin
                    exp_dropped = 1'b1;
                end else begin
                    fifo_q.push_back(bits);
                end
            end
            push_pend = sample_valid;
        end
    end

    always @(negedge clk) begin
        if (armed) begin
            check_value("m1_a", m1_a, model.cmd.left_dir.a);
            check_value("m1_b", m1_b, model.cmd.left_dir.b);
            check_value("m2_a", m2_a, model.cmd.right_dir.a);
            check_value("m2_b", m2_b, model.cmd.right_dir.b);
            check_value("dc_left", dc_left, model.cmd.left_duty);
            check_value("dc_right", dc_right, model.cmd.right_duty);
            check_value("leds", leds, model.leds);
            check_value("node_count", node_count, model.node_count);
            check_value("sample_dropped", sample_dropped, exp_dropped);
            drops_seen += int'(sample_dropped);
        end
    end

    task automatic strobe(input logic [11:0] l, input logic [11:0] m, input logic [11:0] r);
        line_model = {line_bit_after(l, line_model[2]), line_bit_after(m, line_model[1]),
                      line_bit_after(r, line_model[0])};
        pending_q.push_back(line_model);
        left         = l;
        middle       = m;
        right        = r;
        sample_valid = 1'b1;
        @(negedge clk);
        sample_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_idle(input int limit, output int used);
        used = 0;
        while ((pending_q.size() != 0 || fifo_q.size() != 0) && used < limit) begin
            @(negedge clk);
            used++;
        end
        if (pending_q.size() != 0 || fifo_q.size() != 0) begin
            errors++;
            $display("Timeout: frames still waiting after %0d cycles at %0t", limit, $time);
        end
    endtask

    task automatic send_spaced(input logic [11:0] l, input logic [11:0] m,
                               input logic [11:0] r);
        int used;
        strobe(l, m, r);
        wait_idle(34, used);
        repeat (18 - used) @(negedge clk);
    endtask

    task automatic send_pattern(input logic [2:0] bits);
        send_spaced(bits[2] ? 12'd2000 : 12'd300, bits[1] ? 12'd2000 : 12'd300,
                    bits[0] ? 12'd2000 : 12'd300);
    endtask

    initial begin
        int          drops_before;
        int          used;
        logic [2:0]  burst [8];
        void'($urandom(32'h4ee54a28));
        clk          = 1'b0;
        rst          = 1'b1;
        sample_valid = 1'b0;
        left         = '0;
        middle       = '0;
        right        = '0;
        line_model   = 3'b000;
        errors       = 0;
        checks       = 0;
        drops_seen   = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("pwm_left", pwm_left, 1'b0);
        check_value("pwm_right", pwm_right, 1'b0);

        // one and two sensor patterns with full swings between the ends.
        send_pattern(3'b010);
        send_pattern(3'b110);
        send_pattern(3'b100);
        send_pattern(3'b001);
        send_pattern(3'b100);
        send_pattern(3'b011);
        send_pattern(3'b101);
        send_pattern(3'b001);

        // readings in the dead band leave the line bits alone.
        send_spaced(12'd900, 12'd900, 12'd900);
        send_spaced(12'd1000, 12'd650, 12'd1100);
        send_pattern(3'b000);

        // no node has been seen before this point.
        send_pattern(3'b111);
        send_pattern(3'b111);
        send_pattern(3'b111);
        send_pattern(3'b010);
        send_pattern(3'b111);
        check_value("node_count after two nodes", node_count, 4'd2);

        burst        = '{3'b010, 3'b110, 3'b100, 3'b011, 3'b001, 3'b111, 3'b000, 3'b010};
        drops_before = drops_seen;
        foreach (burst[i]) begin
            strobe(burst[i][2] ? 12'd1500 + 12'(i) : 12'd200, burst[i][1] ? 12'd1500 : 12'd200,
                   burst[i][0] ? 12'd1500 : 12'd200 + 12'(i));
        end
        wait_idle(120, used);
        repeat (4) @(negedge clk);
        check_value("dropped pulses at least 3", (drops_seen - drops_before) >= 3, 1'b1);

        repeat (200) begin
            send_spaced(12'($urandom % 2048), 12'($urandom % 2048), 12'($urandom % 2048));
        end
        repeat (20) @(negedge clk);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: rtl/line_follower_top.sv
`timescale 1ns/1ps

module line_follower_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sample_valid,
    input  sensor_pkg::adc_sample_t left,
    input  sensor_pkg::adc_sample_t middle,
    input  sensor_pkg::adc_sample_t right,
    output logic                   m1_a,
    output logic                   m1_b,
    output logic                   m2_a,
    output logic                   m2_b,
    output drive_pkg::duty_t       dc_left,
    output drive_pkg::duty_t       dc_right,
    output logic                   pwm_left,
    output logic                   pwm_right,
    output drive_pkg::led_status_t leds,
    output logic [3:0]             node_count,
    output logic                   sample_dropped
);

    sensor_pkg::sensor_frame_t sampled_frame;
    sensor_pkg::sensor_frame_t head_frame;
    drive_pkg::drive_cmd_t     cmd;
    logic                      push;
    logic                      pop;
    logic                      empty;
    logic                      update;

    sensor_sampler sensor_sampler_i (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .left         (left),
        .middle       (middle),
        .right        (right),
        .frame        (sampled_frame),
        .push         (push)
    );

    frame_fifo frame_fifo_i (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_frame (sampled_frame),
        .pop        (pop),
        .head_frame (head_frame),
        .empty      (empty),
        .dropped    (sample_dropped)
    );

    line_follower line_follower_i (
        .clk        (clk),
        .rst        (rst),
        .update     (update),
        .empty      (empty),
        .head_frame (head_frame),
        .pop        (pop),
        .cmd        (cmd),
        .leds       (leds),
        .node_count (node_count)
    );

    pwm_generator pwm_generator_i (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .update    (update),
        .pwm_left  (pwm_left),
        .pwm_right (pwm_right)
    );

    // motor 1 is the left wheel, motor 2 the right.
    assign m1_a     = cmd.left_dir.a;
    assign m1_b     = cmd.left_dir.b;
    assign m2_a     = cmd.right_dir.a;
    assign m2_b     = cmd.right_dir.b;
    assign dc_left  = cmd.left_duty;
    assign dc_right = cmd.right_duty;

endmodule

// File: rtl/pwm_generator.sv
`timescale 1ns/1ps

module pwm_generator (
    input  logic                  clk,
    input  logic                  rst,
    input  drive_pkg::drive_cmd_t cmd,
    output logic                  update,
    output logic                  pwm_left,
    output logic                  pwm_right
);

    logic [3:0]       cnt;
    drive_pkg::duty_t left_duty_q;
    drive_pkg::duty_t right_duty_q;

    // last step of the period.
    assign update = (cnt == 4'd15);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt          <= '0;
            left_duty_q  <= '0;
            right_duty_q <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            // new duties take effect from step 0 of the next period.
            if (update) begin
                left_duty_q  <= cmd.left_duty;
                right_duty_q <= cmd.right_duty;
            end
        end
    end

    assign pwm_left  = (cnt < left_duty_q);
    assign pwm_right = (cnt < right_duty_q);

endmodule

// File: rtl/line_follower.sv
`timescale 1ns/1ps
`include "robot_settings.svh"

module line_follower (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      update,
    input  logic                      empty,
    input  sensor_pkg::sensor_frame_t head_frame,
    output logic                      pop,
    output drive_pkg::drive_cmd_t     cmd,
    output drive_pkg::led_status_t    leds,
    output logic [3:0]                node_count
);

    drive_pkg::follow_state_e state;
    drive_pkg::line_error_t   prev_error;
    drive_pkg::line_error_t   error;
    drive_pkg::duty_t         base_left;
    drive_pkg::duty_t         base_right;
    drive_pkg::duty_t         duty_left;
    drive_pkg::duty_t         duty_right;
    logic signed [7:0]        error_w;
    logic signed [7:0]        prev_w;
    logic signed [7:0]        correction;
    logic signed [7:0]        sum_left;
    logic signed [7:0]        sum_right;

    function automatic drive_pkg::duty_t clamp_duty(input logic signed [7:0] value);
        if (value < 0) begin
            return '0;
        end else if (value > `DUTY_MAX) begin
            return drive_pkg::duty_t'(`DUTY_MAX);
        end else begin
            return value[3:0];
        end
    endfunction

    // one frame per PWM period, taken only when there is one.
    assign pop = update && !empty;

    // weighted position of the line under the sensor bar.
    always_comb begin
        case (head_frame.line)
            3'b110:  error = -3'sd1;
            3'b100:  error = -3'sd2;
            3'b011:  error = 3'sd1;
            3'b001:  error = 3'sd2;
            default: error = 3'sd0;
        endcase
    end

    // the wheel on the side of the line slows down.
    always_comb begin
        if (error < 0) begin
            base_left  = 4'd4;
            base_right = 4'd7;
        end else if (error > 0) begin
            base_left  = 4'd7;
            base_right = 4'd4;
        end else begin
            base_left  = 4'd7;
            base_right = 4'd7;
        end
    end

    always_comb begin
        error_w    = error;
        prev_w     = prev_error;
        correction = `KP * error_w + `KD * (error_w - prev_w);
        sum_left   = $signed({4'b0000, base_left}) + correction;
        sum_right  = $signed({4'b0000, base_right}) - correction;
        duty_left  = clamp_duty(sum_left);
        duty_right = clamp_duty(sum_right);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= drive_pkg::on_line;
            prev_error       <= '0;
            cmd.left_dir.a   <= 1'b1;
            cmd.left_dir.b   <= 1'b0;
            cmd.right_dir.a  <= 1'b1;
            cmd.right_dir.b  <= 1'b0;
            cmd.left_duty    <= '0;
            cmd.right_duty   <= '0;
            leds.red         <= 3'b000;
            leds.green       <= 3'b111;
            leds.blue        <= 3'b000;
            node_count       <= '0;
        end else if (pop) begin
            case (head_frame.line)
                3'b111: begin
                    // pivot at the node, right wheel in reverse.
                    state           <= drive_pkg::at_node;
                    cmd.left_dir.a  <= 1'b1;
                    cmd.left_dir.b  <= 1'b0;
                    cmd.right_dir.a <= 1'b0;
                    cmd.right_dir.b <= 1'b1;
                    cmd.left_duty   <= 4'd7;
                    cmd.right_duty  <= 4'd3;
                    leds.red        <= 3'b000;
                    leds.green      <= 3'b000;
                    leds.blue       <= 3'b111;
                    if (state != drive_pkg::at_node) begin
                        node_count <= node_count + 1'b1;
                    end
                end
                3'b000: begin
                    // nothing seen, so the last command carries on.
                    state      <= drive_pkg::lost;
                    leds.red   <= 3'b111;
                    leds.green <= 3'b000;
                    leds.blue  <= 3'b000;
                end
                default: begin
                    state           <= drive_pkg::on_line;
                    cmd.left_dir.a  <= 1'b1;
                    cmd.left_dir.b  <= 1'b0;
                    cmd.right_dir.a <= 1'b1;
                    cmd.right_dir.b <= 1'b0;
                    cmd.left_duty   <= duty_left;
                    cmd.right_duty  <= duty_right;
                    leds.red        <= 3'b000;
                    leds.green      <= 3'b111;
                    leds.blue       <= 3'b000;
                    // the previous error only moves on on-line frames.
                    prev_error      <= error;
                end
            endcase
        end
    end

endmodule

// File: rtl/frame_fifo.sv
`timescale 1ns/1ps
`include "robot_settings.svh"

module frame_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  sensor_pkg::sensor_frame_t push_frame,
    input  logic                      pop,
    output sensor_pkg::sensor_frame_t head_frame,
    output logic                      empty,
    output logic                      dropped
);

    sensor_pkg::sensor_frame_t mem [`FIFO_DEPTH];

    logic [$clog2(`FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(`FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(`FIFO_DEPTH+1)-1:0] count;
    logic                             full;
    logic                             push_ok;
    logic                             pop_ok;

    assign full    = (count == `FIFO_DEPTH);
    assign empty   = (count == 0);
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    // show-ahead, the oldest frame is always on the output.
    assign head_frame = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_frame;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            dropped <= 1'b0;
        end else begin
            dropped <= push && full;
            if (push_ok) begin
                if (wr_ptr == `FIFO_DEPTH - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop_ok) begin
                if (rd_ptr == `FIFO_DEPTH - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("frame_fifo: pop while empty");

    count_in_range: assert property (@(posedge clk) disable iff (rst) count <= `FIFO_DEPTH)
        else $error("frame_fifo: fill count above depth");

endmodule

// File: rtl/sensor_sampler.sv
`timescale 1ns/1ps
`include "robot_settings.svh"

module sensor_sampler (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sample_valid,
    input  sensor_pkg::adc_sample_t   left,
    input  sensor_pkg::adc_sample_t   middle,
    input  sensor_pkg::adc_sample_t   right,
    output sensor_pkg::sensor_frame_t frame,
    output logic                      push
);

    sensor_pkg::adc_sample_t left_q;
    sensor_pkg::adc_sample_t middle_q;
    sensor_pkg::adc_sample_t right_q;
    sensor_pkg::line_bits_t  line_q;
    sensor_pkg::line_bits_t  line_d;

    // a reading that sits between the two thresholds keeps the old bit.
    function automatic logic hyst_bit(input sensor_pkg::adc_sample_t sample,
                                      input logic old_bit);
        if (sample > `LINE_HIGH_THRESH) begin
            return 1'b1;
        end else if (sample < `LINE_LOW_THRESH) begin
            return 1'b0;
        end else begin
            return old_bit;
        end
    endfunction

    assign line_d = {hyst_bit(left, line_q[2]),
                     hyst_bit(middle, line_q[1]),
                     hyst_bit(right, line_q[0])};

    always_ff @(posedge clk) begin
        if (rst) begin
            line_q <= '0;
            push   <= 1'b0;
        end else begin
            push <= sample_valid;
            if (sample_valid) begin
                line_q <= line_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            left_q   <= left;
            middle_q <= middle;
            right_q  <= right;
        end
    end

    assign frame = '{left: left_q, middle: middle_q, right: right_q, line: line_q};

    // strobes must be at least one idle cycle apart.
    push_single_cycle: assert property (@(posedge clk) disable iff (rst) push |=> !push)
        else $error("sensor_sampler: push high on two consecutive cycles");

endmodule

// File: rtl/drive_pkg.sv
package drive_pkg;

    // wheel duty in sixteenths of a PWM period.
    typedef logic [3:0] duty_t;

    // signed line error, -2 is far left of the line and +2 far right.
    typedef logic signed [2:0] line_error_t;

    // H-bridge inputs of one motor; a=1 b=0 drives forward, a=0 b=1 reverse.
    typedef struct packed {
        logic a;
        logic b;
    } motor_dir_t;

    typedef struct packed {
        motor_dir_t left_dir;
        motor_dir_t right_dir;
        duty_t      left_duty;
        duty_t      right_duty;
    } drive_cmd_t;

    // one bit per LED in each colour field.
    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [2:0] blue;
    } led_status_t;

    typedef enum logic [1:0] {
        on_line = 2'd0,
        at_node = 2'd1,
        lost    = 2'd2
    } follow_state_e;

endpackage

// File: rtl/sensor_pkg.sv
package sensor_pkg;

    // one 12-bit reflectance reading from the ADC.
    typedef logic [11:0] adc_sample_t;

    // bit 2 is the left sensor, bit 1 the center and bit 0 the right.
    // a set bit means that sensor sees the line.
    typedef logic [2:0] line_bits_t;

    // one sample of all three sensors with the line bits derived from it.
    // 3 x 12 + 3 = 39 bits.
    typedef struct packed {
        adc_sample_t left;
        adc_sample_t middle;
        adc_sample_t right;
        line_bits_t  line;
    } sensor_frame_t;

endpackage

// File: rtl/robot_settings.svh
`ifndef ROBOT_SETTINGS_SVH
`define ROBOT_SETTINGS_SVH

// a sensor reading above this level sets its line bit.
`define LINE_HIGH_THRESH 1200

// a sensor reading below this level clears its line bit.
`define LINE_LOW_THRESH 700

// number of sensor frames the FIFO holds before it starts dropping.
`define FIFO_DEPTH 4

// proportional gain of the steering correction.
`define KP 1

// derivative gain, applied to the change of the line error.
`define KD 1

// highest duty the PWM generator accepts, 15 of 16 steps.
`define DUTY_MAX 15

`endif
